// File: source/dl_pkg.sv
package dl_pkg;

	// --------------------------------------------------
	// stream beat from the io controller
	// --------------------------------------------------
	localparam int DL_ADDR_W = 24;

	typedef logic [4:0] dl_index_t;

	localparam dl_index_t IDX_ROM      = 5'd0;
	localparam dl_index_t IDX_DISK_INT = 5'd1;
	localparam dl_index_t IDX_DISK_EXT = 5'd2;
	// parameter ram, never written to sdram
	localparam dl_index_t IDX_PRAM     = 5'd31;

	typedef struct packed {
		dl_index_t            index;
		logic [DL_ADDR_W-1:0] addr;
		logic [7:0]           data;
		logic                 wr;
	} dl_beat_t;

	// --------------------------------------------------
	// floppy images and rom size
	// --------------------------------------------------
	// last word address of 819200 and 409600 byte images
	localparam logic [DL_ADDR_W-2:0] DS_LAST_WORD = 23'd409599;
	localparam logic [DL_ADDR_W-2:0] SS_LAST_WORD = 23'd204799;

	// bit 0 internal drive, bit 1 external drive
	typedef struct packed {
		logic [1:0] ds;
		logic [1:0] ss;
	} disk_status_t;

	// 0..3 for 64K, 128K, 256K, 512K
	typedef logic [1:0] rom_size_t;

endpackage

// File: source/mem_pkg.sv
package mem_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int WORD_ADDR_W = 21;
	localparam int MEM_ADDR_W  = 25;
	localparam int CPU_ADDR_W  = 22;
	localparam int DATA_W      = 16;
	localparam int BYTE_W      = 8;

	typedef logic [DATA_W-1:0] mem_word_t;

	// region tag used by every download write
	localparam logic [3:0] DL_REGION = 4'd1;

	// --------------------------------------------------
	// sdram word address, two views
	// --------------------------------------------------
	typedef struct packed {
		logic [3:0]             region;
		logic [WORD_ADDR_W-1:0] word;
	} dl_addr_t;

	typedef struct packed {
		logic [2:0]             zero;
		logic                   rom;
		logic [WORD_ADDR_W-1:0] word;
	} cpu_addr_t;

	typedef union packed {
		dl_addr_t  dl;
		cpu_addr_t cpu;
	} mem_addr_u;

	// ds is {upper, lower}
	typedef struct packed {
		mem_addr_u  addr;
		mem_word_t  wdata;
		logic [1:0] ds;
		logic       we;
		logic       oe;
	} mem_req_t;

	// cpu side strobes and enables are active low
	typedef struct packed {
		logic [CPU_ADDR_W-1:0] addr;
		logic                  uds_n;
		logic                  lds_n;
		logic                  rom_oe_n;
		logic                  ram_oe_n;
		logic                  ram_we_n;
	} cpu_req_t;

endpackage

// File: source/download_tracker.sv
`timescale 1ns/1ns

module download_tracker (
	input  logic                 clk32,
	input  logic                 reset_i,
	input  dl_pkg::dl_beat_t     dl_i,
	input  logic                 download_i,
	input  logic [1:0]           eject_i,
	output dl_pkg::disk_status_t status_o,
	output logic [1:0]           disk_ins_o,
	output logic [1:0]           disk_ds_o,
	output dl_pkg::rom_size_t    rom_size_o,
	output logic                 machine_se_o,
	output logic                 rom_download_o
);
	import dl_pkg::*;

	// drive 0 is the internal floppy
	localparam dl_index_t DRIVE_IDX [2] = '{IDX_DISK_INT, IDX_DISK_EXT};

	logic                 download_d;
	logic                 download_end;
	logic [DL_ADDR_W-2:0] last_word;
	disk_status_t         status_q;
	rom_size_t            rom_size_q;

	// stream counts bytes, image sizes are compared in words
	assign last_word    = dl_i.addr[DL_ADDR_W-1:1];
	assign download_end = ~download_i & download_d;

	always_ff @(posedge clk32) begin
		if (reset_i) begin
			download_d <= 1'b0;
		end else begin
			download_d <= download_i;
		end
	end

	// --------------------------------------------------
	// disk size flags, eject wins
	// --------------------------------------------------
	always_ff @(posedge clk32) begin
		if (reset_i) begin
			status_q <= '0;
		end else begin
			for (int d = 0; d < 2; d++) begin
				if (eject_i[d]) begin
					status_q.ds[d] <= 1'b0;
					status_q.ss[d] <= 1'b0;
				end else if (download_end && dl_i.index == DRIVE_IDX[d]) begin
					status_q.ds[d] <= (last_word == DS_LAST_WORD);
					status_q.ss[d] <= (last_word == SS_LAST_WORD);
				end
			end
		end
	end

	// rom size from the highest address seen
	always_ff @(posedge clk32) begin
		if (reset_i) begin
			rom_size_q <= '0;
		end else if (dl_i.wr && dl_i.index == IDX_ROM) begin
			rom_size_q <= {dl_i.addr[18] | dl_i.addr[17],
				dl_i.addr[18] | (dl_i.addr[16] & ~dl_i.addr[17])};
		end
	end

	assign status_o       = status_q;
	assign disk_ds_o      = status_q.ds;
	assign disk_ins_o     = status_q.ds | status_q.ss;
	assign rom_size_o     = rom_size_q;
	// 256K and 512K roms are SE roms
	assign machine_se_o   = rom_size_q[1];
	assign rom_download_o = download_i & (dl_i.index == IDX_ROM);

endmodule

// File: source/download_mapper.sv
`timescale 1ns/1ns

module download_mapper #(
	parameter logic [mem_pkg::WORD_ADDR_W-1:0] INT_BASE = 21'h080000,
	parameter logic [mem_pkg::WORD_ADDR_W-1:0] EXT_BASE = 21'h100000
) (
	input  logic              clk32,
	input  logic              reset_i,
	input  dl_pkg::dl_beat_t  dl_i,
	input  logic              download_i,
	input  logic              dio_bus_i,
	output mem_pkg::mem_req_t dl_req_o,
	output logic              download_cycle_o,
	output logic              slot_end_n_o
);
	import dl_pkg::*;
	import mem_pkg::*;

	logic [WORD_ADDR_W-1:0] half_addr;
	logic [WORD_ADDR_W-1:0] region_word;
	mem_addr_u              addr_d;
	mem_addr_u              addr_q;
	mem_word_t              wdata_q;
	logic [1:0]             lanes_d;
	logic [1:0]             lanes_q;
	logic                   strobe;
	logic                   pending_q;
	logic                   cycle_d;
	logic                   slot_end;

	// --------------------------------------------------
	// byte address to sdram word
	// --------------------------------------------------
	assign half_addr = dl_i.addr[WORD_ADDR_W:1];

	// disk images sit behind the os rom
	always_comb begin
		case (dl_i.index)
			IDX_ROM:      region_word = half_addr;
			IDX_DISK_INT: region_word = INT_BASE + half_addr;
			default:      region_word = EXT_BASE + half_addr;
		endcase
	end

	always_comb begin
		addr_d.dl.region = DL_REGION;
		addr_d.dl.word   = region_word;
	end

	// even byte goes to the upper lane
	assign lanes_d = {~dl_i.addr[0], dl_i.addr[0]};
	assign strobe  = dl_i.wr & (dl_i.index != IDX_PRAM);

	always_ff @(posedge clk32) begin
		if (strobe) begin
			addr_q  <= addr_d;
			wdata_q <= {2{dl_i.data}};
			lanes_q <= lanes_d;
		end
	end

	// --------------------------------------------------
	// pending write and slot end
	// --------------------------------------------------
	always_ff @(posedge clk32) begin
		if (reset_i) begin
			pending_q <= 1'b0;
			cycle_d   <= 1'b0;
		end else begin
			cycle_d <= download_cycle_o;
			// a new strobe beats the clear
			if (strobe) begin
				pending_q <= 1'b1;
			end else if (slot_end) begin
				pending_q <= 1'b0;
			end
		end
	end

	assign download_cycle_o = download_i & dio_bus_i;
	assign slot_end         = cycle_d & ~download_cycle_o;
	assign slot_end_n_o     = ~slot_end;

	always_comb begin
		dl_req_o.addr  = addr_q;
		dl_req_o.wdata = wdata_q;
		dl_req_o.ds    = lanes_q;
		dl_req_o.we    = pending_q;
		dl_req_o.oe    = 1'b0;
	end

endmodule

// File: source/memory_port_mux.sv
`timescale 1ns/1ns

module memory_port_mux (
	input  logic               download_cycle_i,
	input  mem_pkg::mem_req_t  dl_req_i,
	input  mem_pkg::cpu_req_t  cpu_i,
	input  logic               disk_read_ack_i,
	input  mem_pkg::mem_word_t sdram_rdata_i,
	output mem_pkg::mem_req_t  mem_o,
	output mem_pkg::mem_word_t cpu_rdata_o
);
	import mem_pkg::*;

	mem_req_t  cpu_req;
	mem_word_t disk_word;

	// --------------------------------------------------
	// cpu request in the cpu view of the address
	// --------------------------------------------------
	always_comb begin
		cpu_req.addr.cpu.zero = '0;
		cpu_req.addr.cpu.rom  = ~cpu_i.rom_oe_n;
		cpu_req.addr.cpu.word = cpu_i.addr[WORD_ADDR_W:1];
		// write data joins the request outside this port
		cpu_req.wdata         = '0;
		cpu_req.ds            = {~cpu_i.uds_n, ~cpu_i.lds_n};
		cpu_req.we            = ~cpu_i.ram_we_n;
		cpu_req.oe            = ~cpu_i.ram_oe_n | ~cpu_i.rom_oe_n;
	end

	// floppy images are byte wide, pick the addressed byte
	assign disk_word = cpu_i.addr[0] ? {2{sdram_rdata_i[BYTE_W-1:0]}}
		: {2{sdram_rdata_i[DATA_W-1:BYTE_W]}};

	always_comb begin
		if (download_cycle_i) begin
			mem_o       = dl_req_i;
			// all ones keeps the screen black while loading
			cpu_rdata_o = '1;
		end else begin
			mem_o = cpu_req;
			if (disk_read_ack_i) begin
				cpu_rdata_o = disk_word;
			end else begin
				cpu_rdata_o = sdram_rdata_i;
			end
		end
	end

endmodule

// File: source/reset_stretcher.sv
`timescale 1ns/1ns

module reset_stretcher #(
	parameter int unsigned RESET_HOLD = 65535
) (
	input  logic       clk32,
	input  logic       reset_i,
	input  logic       clk8_en_i,
	input  logic       reset_req_i,
	input  logic       rom_download_i,
	input  logic [2:0] config_i,
	output logic       sys_reset_n_o
);

	localparam int CNT_W = $clog2(RESET_HOLD + 1);
	localparam logic [CNT_W-1:0] HOLD = CNT_W'(RESET_HOLD);

	logic [CNT_W-1:0] cnt_q;
	logic [2:0]       config_q;
	logic             source;

	// any change of memory or cpu choice restarts the machine
	assign source = reset_req_i | rom_download_i | (config_i != config_q);

	always_ff @(posedge clk32) begin
		if (reset_i) begin
			cnt_q    <= HOLD;
			config_q <= config_i;
		end else if (clk8_en_i) begin
			config_q <= config_i;
			if (source) begin
				cnt_q <= HOLD;
			end else if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	assign sys_reset_n_o = (cnt_q == '0);

endmodule

// File: source/plus_memory_top.sv
`timescale 1ns/1ns

module plus_memory_top #(
	parameter logic [mem_pkg::WORD_ADDR_W-1:0] INT_BASE   = 21'h080000,
	parameter logic [mem_pkg::WORD_ADDR_W-1:0] EXT_BASE   = 21'h100000,
	parameter int unsigned                     RESET_HOLD = 65535
) (
	input  logic               clk32,
	input  logic               reset_i,
	input  dl_pkg::dl_beat_t   dl_i,
	input  logic               download_i,
	input  logic               dio_bus_i,
	input  logic [1:0]         eject_i,
	input  mem_pkg::cpu_req_t  cpu_i,
	input  logic               disk_read_ack_i,
	input  mem_pkg::mem_word_t sdram_rdata_i,
	input  logic               clk8_en_i,
	input  logic               reset_req_i,
	input  logic [2:0]         config_i,
	output mem_pkg::mem_req_t  mem_o,
	output mem_pkg::mem_word_t cpu_rdata_o,
	output logic [1:0]         disk_ins_o,
	output logic [1:0]         disk_ds_o,
	output dl_pkg::rom_size_t  rom_size_o,
	output logic               machine_se_o,
	output logic               slot_end_n_o,
	output logic               sys_reset_n_o
);
	import dl_pkg::*;
	import mem_pkg::*;

	disk_status_t disk_status;
	mem_req_t     dl_req;
	logic         download_cycle;
	logic         rom_download;

	// --------------------------------------------------
	// download stream
	// --------------------------------------------------
	download_tracker i_tracker (
		.clk32          (clk32),
		.reset_i        (reset_i),
		.dl_i           (dl_i),
		.download_i     (download_i),
		.eject_i        (eject_i),
		.status_o       (disk_status),
		.disk_ins_o     (disk_ins_o),
		.disk_ds_o      (disk_ds_o),
		.rom_size_o     (rom_size_o),
		.machine_se_o   (machine_se_o),
		.rom_download_o (rom_download)
	);

	download_mapper #(
		.INT_BASE (INT_BASE),
		.EXT_BASE (EXT_BASE)
	) i_mapper (
		.clk32            (clk32),
		.reset_i          (reset_i),
		.dl_i             (dl_i),
		.download_i       (download_i),
		.dio_bus_i        (dio_bus_i),
		.dl_req_o         (dl_req),
		.download_cycle_o (download_cycle),
		.slot_end_n_o     (slot_end_n_o)
	);

	// --------------------------------------------------
	// sdram port and system reset
	// --------------------------------------------------
	memory_port_mux i_mux (
		.download_cycle_i (download_cycle),
		.dl_req_i         (dl_req),
		.cpu_i            (cpu_i),
		.disk_read_ack_i  (disk_read_ack_i),
		.sdram_rdata_i    (sdram_rdata_i),
		.mem_o            (mem_o),
		.cpu_rdata_o      (cpu_rdata_o)
	);

	reset_stretcher #(
		.RESET_HOLD (RESET_HOLD)
	) i_reset (
		.clk32          (clk32),
		.reset_i        (reset_i),
		.clk8_en_i      (clk8_en_i),
		.reset_req_i    (reset_req_i),
		.rom_download_i (rom_download),
		.config_i       (config_i),
		.sys_reset_n_o  (sys_reset_n_o)
	);

endmodule

// File: testbench/plus_memory_assert.sv
`timescale 1ns/1ns

module plus_memory_assert (
	input  logic                 clk32,
	input  logic                 reset_i,
	input  logic                 download_cycle_i,
	input  mem_pkg::mem_req_t    mem_i,
	input  dl_pkg::disk_status_t status_i,
	input  logic                 slot_end_n_i
);

	// the download owns the port, no sdram read may start
	no_read_in_download: assert property (
		@(posedge clk32) disable iff (reset_i)
		download_cycle_i |-> !mem_i.oe
	) else $error("read enable high during a download cycle");

	// an image is either double or single sided
	one_size_per_drive: assert property (
		@(posedge clk32) disable iff (reset_i)
		(status_i.ds & status_i.ss) == 2'b00
	) else $error("a drive has both size flags set");

	slot_end_after_cycle: assert property (
		@(posedge clk32) disable iff (reset_i)
		!slot_end_n_i |-> $past(download_cycle_i)
	) else $error("slot end pulse without a download cycle before it");

endmodule

bind plus_memory_top plus_memory_assert i_assert (
	.clk32            (clk32),
	.reset_i          (reset_i),
	.download_cycle_i (download_cycle),
	.mem_i            (mem_o),
	.status_i         (disk_status),
	.slot_end_n_i     (slot_end_n_o)
);

// File: testbench/tb_plus_memory.sv
`timescale 1ns/1ns

module tb_plus_memory #(
	parameter int unsigned SEED = 65667
);
	import dl_pkg::*;
	import mem_pkg::*;

	localparam int                     RESET_HOLD   = 12;
	localparam int                     HOLD_TIMEOUT = 400;
	localparam logic [WORD_ADDR_W-1:0] INT_WORD     = 21'h080000;
	localparam logic [WORD_ADDR_W-1:0] EXT_WORD     = 21'h100000;

	logic         clk32;
	logic         reset_i;
	dl_beat_t     dl_i;
	logic         download_i;
	logic         dio_bus_i;
	logic [1:0]   eject_i;
	cpu_req_t     cpu_i;
	logic         disk_read_ack_i;
	mem_word_t    sdram_rdata_i;
	logic         clk8_en_i;
	logic         reset_req_i;
	logic [2:0]   config_i;
	mem_req_t     mem_o;
	mem_word_t    cpu_rdata_o;
	logic [1:0]   disk_ins_o;
	logic [1:0]   disk_ds_o;
	rom_size_t    rom_size_o;
	logic         machine_se_o;
	logic         slot_end_n_o;
	logic         sys_reset_n_o;

	logic [31:0]  lfsr_q;
	logic [1:0]   phase;
	mem_req_t     exp_req;
	disk_status_t exp_status;

	plus_memory_top #(
		.RESET_HOLD (RESET_HOLD)
	) i_dut (.*);

	initial begin
		clk32 = 1'b0;
		forever #4 clk32 = ~clk32;
	end

	// 8 MHz enable on one cycle in four
	initial begin
		phase     <= 2'd0;
		clk8_en_i <= 1'b0;
		forever begin
			@(posedge clk32);
			phase     <= phase + 2'd1;
			clk8_en_i <= (phase == 2'd3);
		end
	end

	// --------------------------------------------------
	// random bits and expected values
	// --------------------------------------------------
	// fibonacci lfsr with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			val    = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic mem_req_t ref_dl_req(input dl_index_t idx, input logic [23:0] byte_addr,
			input logic [7:0] data_byte);
		mem_req_t               r;
		logic [WORD_ADDR_W-1:0] base;
		base = (idx == IDX_ROM) ? '0 : (idx == IDX_DISK_INT) ? INT_WORD : EXT_WORD;
		r.addr.dl.region = 4'd1;
		r.addr.dl.word   = base + byte_addr[21:1];
		r.wdata          = {data_byte, data_byte};
		r.ds             = byte_addr[0] ? 2'b01 : 2'b10;
		r.we             = 1'b1;
		r.oe             = 1'b0;
		return r;
	endfunction

	function automatic mem_req_t ref_cpu_req(input cpu_req_t c);
		mem_req_t r;
		r               = '0;
		r.addr.cpu.rom  = ~c.rom_oe_n;
		r.addr.cpu.word = c.addr[21:1];
		r.ds            = {~c.uds_n, ~c.lds_n};
		r.we            = ~c.ram_we_n;
		r.oe            = ~(c.ram_oe_n & c.rom_oe_n);
		return r;
	endfunction

	// floppy bytes come back on both halves
	function automatic mem_word_t ref_rdata(input cpu_req_t c, input logic ack,
			input mem_word_t r);
		if (!ack) begin
			return r;
		end
		return c.addr[0] ? {2{r[7:0]}} : {2{r[15:8]}};
	endfunction

	// random byte address inside one rom size band
	function automatic logic [23:0] band_addr(input int s);
		logic [23:0] lower;
		logic [23:0] off;
		lower = (s == 0) ? 24'd0 : (24'h010000 << (s - 1));
		off   = (s < 2) ? 24'(take_bits(16)) : 24'(take_bits(15 + s));
		return lower + off;
	endfunction

	function automatic disk_status_t observed_status();
		return {disk_ds_o, disk_ins_o & ~disk_ds_o};
	endfunction

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_req(input string name, input mem_req_t exp, input mem_req_t act);
		if (act !== exp) begin
			stop_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_word(input string name, input mem_word_t exp, input mem_word_t act);
		if (act !== exp) begin
			stop_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_status(input string name, input disk_status_t exp,
			input disk_status_t act);
		if (act !== exp) begin
			stop_run($sformatf("FAIL %s expected %b actual %b", name, exp, act));
		end
	endtask

	task automatic check_size(input string name, input rom_size_t exp, input rom_size_t act);
		if (act !== exp) begin
			stop_run($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_run($sformatf("FAIL %s expected %b actual %b", name, exp, act));
		end
	endtask

	// port contents on every cycle
	always @(negedge clk32) begin
		if (!reset_i) begin
			if (download_i && dio_bus_i) begin
				check_req("download request", exp_req, mem_o);
				check_word("read data in download", '1, cpu_rdata_o);
			end else begin
				check_req("cpu request", ref_cpu_req(cpu_i), mem_o);
				check_word("cpu read data",
					ref_rdata(cpu_i, disk_read_ack_i, sdram_rdata_i), cpu_rdata_o);
			end
		end
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	task automatic send_beat(input dl_index_t idx, input logic [23:0] byte_addr,
			input logic [7:0] data_byte);
		@(posedge clk32);
		dl_i       <= '{index: idx, addr: byte_addr, data: data_byte, wr: 1'b1};
		download_i <= 1'b1;
		if (idx != IDX_PRAM) begin
			exp_req <= ref_dl_req(idx, byte_addr, data_byte);
		end
		// request is registered and the slot opens a cycle later
		@(posedge clk32);
		dl_i.wr   <= 1'b0;
		dio_bus_i <= 1'b1;
		@(posedge clk32);
		dio_bus_i  <= 1'b0;
		exp_req.we <= 1'b0;
		@(negedge clk32);
		check_bit("slot end", 1'b0, slot_end_n_o);
	endtask

	// flags follow one edge after the first low cycle
	task automatic end_download();
		@(posedge clk32);
		download_i <= 1'b0;
		@(posedge clk32);
		@(negedge clk32);
	endtask

	task automatic send_disk(input int drive, input logic [23:0] last_addr);
		dl_index_t idx;
		idx = (drive == 0) ? IDX_DISK_INT : IDX_DISK_EXT;
		for (int n = 0; n < 3; n++) begin
			send_beat(idx, 24'(take_bits(19)), 8'(take_bits(8)));
		end
		send_beat(idx, last_addr, 8'(take_bits(8)));
		end_download();
		exp_status.ds[drive] = (last_addr == 24'd819199);
		exp_status.ss[drive] = (last_addr == 24'd409599);
		check_status("disk flags", exp_status, observed_status());
	endtask

	task automatic eject_drive(input int drive);
		@(posedge clk32);
		eject_i <= 2'b01 << drive;
		@(posedge clk32);
		eject_i <= 2'b00;
		@(negedge clk32);
		exp_status.ds[drive] = 1'b0;
		exp_status.ss[drive] = 1'b0;
		check_status("eject", exp_status, observed_status());
	endtask

	task automatic wait_reset_level(input logic level, input string name);
		int cycles;
		cycles = 0;
		@(negedge clk32);
		while (sys_reset_n_o !== level) begin
			cycles++;
			if (cycles > HOLD_TIMEOUT) begin
				stop_run($sformatf("%s: system reset never reached %b", name, level));
			end
			@(negedge clk32);
		end
	endtask

	// count enables until the system reset is released
	task automatic count_hold(input string name);
		int enables;
		int cycles;
		enables = 0;
		cycles  = 0;
		while (sys_reset_n_o !== 1'b1) begin
			if (clk8_en_i) begin
				enables++;
			end
			cycles++;
			if (cycles > HOLD_TIMEOUT) begin
				stop_run($sformatf("%s: system reset did not rise in %0d cycles",
					name, HOLD_TIMEOUT));
			end
			@(negedge clk32);
		end
		if (enables < RESET_HOLD) begin
			stop_run($sformatf("FAIL %s expected at least %0d enables actual %0d",
				name, RESET_HOLD, enables));
		end
	endtask

	initial begin
		lfsr_q          = 32'(SEED);
		exp_status      = '0;
		reset_i         <= 1'b1;
		dl_i            <= '0;
		download_i      <= 1'b0;
		dio_bus_i       <= 1'b0;
		eject_i         <= 2'b00;
		cpu_i           <= '{addr: '0, uds_n: 1'b1, lds_n: 1'b1, rom_oe_n: 1'b1,
			ram_oe_n: 1'b1, ram_we_n: 1'b1};
		disk_read_ack_i <= 1'b0;
		sdram_rdata_i   <= '0;
		reset_req_i     <= 1'b0;
		config_i        <= 3'b000;
		exp_req         <= '0;
		repeat (16) @(posedge clk32);
		reset_i <= 1'b0;

		// the last rom address sets the size code
		for (int s = 0; s < 4; s++) begin
			for (int n = 0; n < 4; n++) begin
				send_beat(IDX_ROM, band_addr(s), 8'(take_bits(8)));
			end
			end_download();
			check_size("rom size", 2'(s), rom_size_o);
			check_bit("machine se", s[1], machine_se_o);
		end

		// floppy images of both sizes and an odd one
		send_disk(0, 24'd409599);
		send_disk(0, 24'd819199);
		send_disk(1, 24'd819199 - 24'(2 * (1 + take_bits(10))));
		send_disk(1, 24'd409599);
		eject_drive(0);
		send_disk(0, 24'd819199);

		// parameter ram is never written
		send_beat(IDX_PRAM, 24'(take_bits(8)), 8'(take_bits(8)));
		end_download();
		check_status("pram download", exp_status, observed_status());

		eject_drive(1);

		// cpu side checked cycle by cycle
		for (int n = 0; n < 64; n++) begin
			@(posedge clk32);
			cpu_i           <= cpu_req_t'(27'(take_bits(27)));
			sdram_rdata_i   <= 16'(take_bits(16));
			disk_read_ack_i <= 1'(take_bits(1));
		end

		// reset stretch from the request and from a config change
		@(posedge clk32);
		reset_req_i <= 1'b1;
		wait_reset_level(1'b0, "reset request");
		repeat (8) @(posedge clk32);
		reset_req_i <= 1'b0;
		@(negedge clk32);
		count_hold("reset request");
		@(posedge clk32);
		config_i <= 3'b101;
		wait_reset_level(1'b0, "config change");
		count_hold("config change");

		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: all.f
source/dl_pkg.sv
source/mem_pkg.sv
source/download_tracker.sv
source/download_mapper.sv
source/memory_port_mux.sv
source/reset_stretcher.sv
source/plus_memory_top.sv
testbench/plus_memory_assert.sv
testbench/tb_plus_memory.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_plus_memory
SEED      ?= 65667
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
